// File: verilog/vga_pkg.sv
// Shared raster timing, rectangle and colour definitions, imported by every video module.

package vga_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster geometry for 800x600 at 60 Hz
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Width of every pixel-position word.
    localparam int cnt_w = 11;

    localparam logic [10:0] hor_total       = 11'd1056;
    localparam logic [10:0] hor_blank_start = 11'd800;
    localparam logic [10:0] hor_sync_start  = 11'd840;
    localparam logic [10:0] hor_sync_time   = 11'd128;

    localparam logic [10:0] ver_total       = 11'd628;
    localparam logic [10:0] ver_blank_start = 11'd600;
    localparam logic [10:0] ver_sync_start  = 11'd601;
    localparam logic [10:0] ver_sync_time   = 11'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drawing constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [10:0] rect_width  = 11'd48;
    localparam logic [10:0] rect_height = 11'd64;

    // Orange fill for the rectangle.
    localparam logic [11:0] rect_colour = 12'hF80;

    localparam logic [11:0] border_colour = 12'hFFF;
    localparam logic [11:0] blank_colour  = 12'h000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colour word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A colour is moved around as one 12-bit word but blended per channel,
    // so both views share the same bits. Red sits in the top nibble.
    typedef union packed {
        logic [11:0] word;
        struct packed {
            logic [3:0] r;
            logic [3:0] g;
            logic [3:0] b;
        } ch;
    } rgb_t;

endpackage

// File: verilog/vga_timing.sv
// Raster timing controller producing pixel counters, blanking and sync for 800x600 VGA.

`timescale 1ns/1ns

module vga_timing import vga_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic [cnt_w-1:0] hcount,
    output logic [cnt_w-1:0] vcount,
    output logic             hblnk,
    output logic             vblnk,
    output logic             hsync,
    output logic             vsync
);

    logic [cnt_w-1:0] hcount_nxt;
    logic [cnt_w-1:0] vcount_nxt;
    logic             hblnk_nxt;
    logic             vblnk_nxt;
    logic             hsync_nxt;
    logic             vsync_nxt;
    logic             line_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next raster position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign line_end = (hcount == hor_total - 11'd1);

    always_comb begin
        if (line_end) begin
            hcount_nxt = '0;
        end else begin
            hcount_nxt = hcount + 11'd1;
        end

        // The line counter only moves when the pixel counter wraps.
        if (!line_end) begin
            vcount_nxt = vcount;
        end else if (vcount == ver_total - 11'd1) begin
            vcount_nxt = '0;
        end else begin
            vcount_nxt = vcount + 11'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Region decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Flags are decoded from the next position so that after the register
    // they describe the same pixel as the counters.
    always_comb begin
        hblnk_nxt = (hcount_nxt >= hor_blank_start);
        hsync_nxt = (hcount_nxt >= hor_sync_start) &&
                    (hcount_nxt < hor_sync_start + hor_sync_time);
        vblnk_nxt = (vcount_nxt >= ver_blank_start);
        vsync_nxt = (vcount_nxt >= ver_sync_start) &&
                    (vcount_nxt < ver_sync_start + ver_sync_time);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= hblnk_nxt;
            vblnk  <= vblnk_nxt;
            hsync  <= hsync_nxt;
            vsync  <= vsync_nxt;
        end
    end

endmodule

// File: verilog/draw_background.sv
// Background painter that draws a white border and a position gradient on the visible area.

`timescale 1ns/1ns

module draw_background import vga_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [cnt_w-1:0] hcount,
    input  logic [cnt_w-1:0] vcount,
    input  logic             hblnk,
    input  logic             vblnk,
    input  logic             hsync,
    input  logic             vsync,
    output rgb_t             bg_rgb,
    output logic             hsync_d,
    output logic             vsync_d
);

    rgb_t bg_nxt;
    logic visible;
    logic on_border;

    assign visible = !(hblnk || vblnk);

    // Outermost visible columns and rows.
    assign on_border = (hcount == '0) ||
                       (hcount == hor_blank_start - 11'd1) ||
                       (vcount == '0) ||
                       (vcount == ver_blank_start - 11'd1);

    always_comb begin
        bg_nxt.word = blank_colour;
        if (visible) begin
            if (on_border) begin
                bg_nxt.word = border_colour;
            end else begin
                // Red follows the column, green the row, blue stays low.
                bg_nxt.ch.r = hcount[9:6];
                bg_nxt.ch.g = vcount[9:6];
                bg_nxt.ch.b = 4'd4;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Syncs ride along with the colour so the mixer sees them aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            bg_rgb  <= '0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            bg_rgb  <= bg_nxt;
            hsync_d <= hsync;
            vsync_d <= vsync;
        end
    end

endmodule

// File: verilog/draw_rect.sv
// Rectangle painter that flags pixels covered by a fixed-size rectangle at an external position.

`timescale 1ns/1ns

module draw_rect import vga_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [cnt_w-1:0] hcount,
    input  logic [cnt_w-1:0] vcount,
    input  logic             hblnk,
    input  logic             vblnk,
    input  logic [cnt_w-1:0] rect_x,
    input  logic [cnt_w-1:0] rect_y,
    output logic             rect_on,
    output rgb_t             rect_rgb
);

    logic [cnt_w-1:0] x_q;
    logic [cnt_w-1:0] y_q;
    logic [cnt_w-1:0] x_cur;
    logic [cnt_w-1:0] y_cur;
    logic [cnt_w:0]   x_end;
    logic [cnt_w:0]   y_end;
    logic             frame_start;
    logic             in_x;
    logic             in_y;
    logic             on_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Position latch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign frame_start = (hcount == '0) && (vcount == '0);

    // Pixel (0,0) already uses the position sampled in its own cycle.
    assign x_cur = frame_start ? rect_x : x_q;
    assign y_cur = frame_start ? rect_y : y_q;

    always_ff @(posedge clk) begin
        if (frame_start) begin
            x_q <= rect_x;
            y_q <= rect_y;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Coverage test
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One extra bit keeps the far edge from wrapping.
    assign x_end = {1'b0, x_cur} + {1'b0, rect_width};
    assign y_end = {1'b0, y_cur} + {1'b0, rect_height};

    assign in_x = (hcount >= x_cur) && ({1'b0, hcount} < x_end);
    assign in_y = (vcount >= y_cur) && ({1'b0, vcount} < y_end);

    // Blanking clips whatever part of the rectangle falls off screen.
    assign on_nxt = in_x && in_y && !hblnk && !vblnk;

    always_ff @(posedge clk) begin
        if (rst) begin
            rect_on  <= 1'b0;
            rect_rgb <= '0;
        end else begin
            rect_on       <= on_nxt;
            rect_rgb.word <= on_nxt ? rect_colour : 12'h000;
        end
    end

endmodule

// File: verilog/pixel_mixer.sv
// Pixel mixer that blends the rectangle over the background at half strength and aligns syncs.

`timescale 1ns/1ns

module pixel_mixer import vga_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  rgb_t bg_rgb,
    input  rgb_t rect_rgb,
    input  logic rect_on,
    input  logic hsync_d,
    input  logic vsync_d,
    output rgb_t rgb,
    output logic hsync,
    output logic vsync
);

    logic [4:0] sum_r;
    logic [4:0] sum_g;
    logic [4:0] sum_b;
    rgb_t       mix_nxt;

    // Five-bit sums so the carry survives before halving.
    assign sum_r = {1'b0, rect_rgb.ch.r} + {1'b0, bg_rgb.ch.r};
    assign sum_g = {1'b0, rect_rgb.ch.g} + {1'b0, bg_rgb.ch.g};
    assign sum_b = {1'b0, rect_rgb.ch.b} + {1'b0, bg_rgb.ch.b};

    always_comb begin
        if (rect_on) begin
            mix_nxt.ch.r = sum_r[4:1];
            mix_nxt.ch.g = sum_g[4:1];
            mix_nxt.ch.b = sum_b[4:1];
        end else begin
            mix_nxt.word = bg_rgb.word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            rgb   <= mix_nxt;
            hsync <= hsync_d;
            vsync <= vsync_d;
        end
    end

endmodule

// File: verilog/vga_top.sv
// Top level of the VGA video subsystem, wiring timing, both painters and the mixer together.

`timescale 1ns/1ns

module vga_top import vga_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [cnt_w-1:0] rect_x,
    input  logic [cnt_w-1:0] rect_y,
    output logic             hsync,
    output logic             vsync,
    output rgb_t             rgb
);

    logic [cnt_w-1:0] hcount;
    logic [cnt_w-1:0] vcount;
    logic             hblnk;
    logic             vblnk;
    logic             tim_hsync;
    logic             tim_vsync;
    rgb_t             bg_rgb;
    logic             hsync_d;
    logic             vsync_d;
    logic             rect_on;
    rgb_t             rect_rgb;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync)
    );

    // Both painters run in parallel on the same raster.
    draw_background u_draw_background (
        .clk     (clk),
        .rst     (rst),
        .hcount  (hcount),
        .vcount  (vcount),
        .hblnk   (hblnk),
        .vblnk   (vblnk),
        .hsync   (tim_hsync),
        .vsync   (tim_vsync),
        .bg_rgb  (bg_rgb),
        .hsync_d (hsync_d),
        .vsync_d (vsync_d)
    );

    draw_rect u_draw_rect (
        .clk      (clk),
        .rst      (rst),
        .hcount   (hcount),
        .vcount   (vcount),
        .hblnk    (hblnk),
        .vblnk    (vblnk),
        .rect_x   (rect_x),
        .rect_y   (rect_y),
        .rect_on  (rect_on),
        .rect_rgb (rect_rgb)
    );

    pixel_mixer u_pixel_mixer (
        .clk      (clk),
        .rst      (rst),
        .bg_rgb   (bg_rgb),
        .rect_rgb (rect_rgb),
        .rect_on  (rect_on),
        .hsync_d  (hsync_d),
        .vsync_d  (vsync_d),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

// File: testbench/vga_top_tb.sv
// Testbench for vga_top that models the raster from the output ports and checks every pixel.

`timescale 1ns/1ns

module vga_top_tb import vga_pkg::*; ();

    localparam int n_tests     = 5;
    localparam int h_total     = int'(hor_total);
    localparam int v_total     = int'(ver_total);
    localparam int cycle_limit = (n_tests + 2) * h_total * v_total;

    logic             clk;
    logic             rst;
    logic [cnt_w-1:0] rect_x;
    logic [cnt_w-1:0] rect_y;
    logic             hsync;
    logic             vsync;
    rgb_t             rgb;

    string tbl_name [n_tests];
    int    tbl_x    [n_tests];
    int    tbl_y    [n_tests];

    // Model state, tracked from the top ports alone.
    int    h_pos       = 0;
    int    v_pos       = 0;
    int    h_step;
    int    v_step;
    logic  h_lock      = 1'b0;
    logic  v_lock      = 1'b0;
    logic  hs_prev     = 1'b0;
    logic  vs_prev     = 1'b0;
    int    applied_idx = -1;
    int    cur_x       = 0;
    int    cur_y       = 0;
    string frame_name  = "startup";
    int    frames_seen = 0;
    int    cycle_count = 0;

    vga_top DUT (
        .clk    (clk),
        .rst    (rst),
        .rect_x (rect_x),
        .rect_y (rect_y),
        .hsync  (hsync),
        .vsync  (vsync),
        .rgb    (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_range(input int p, input int lo, input int len);
        return (p >= lo) && (p < lo + len);
    endfunction

    function automatic logic [3:0] half_sum(input logic [3:0] a, input logic [3:0] b);
        return 4'((int'(a) + int'(b)) / 2);
    endfunction

    function automatic rgb_t expected_pixel(input int h, input int v, input int rx,
                                            input int ry);
        rgb_t bg;
        rgb_t rc;
        rgb_t px;
        bg.word = blank_colour;
        rc.word = rect_colour;
        if (h >= int'(hor_blank_start) || v >= int'(ver_blank_start)) begin
            return bg;
        end
        if (h == 0 || h == 799 || v == 0 || v == 599) begin
            bg.word = border_colour;
        end else begin
            bg.ch.r = 4'((h >> 6) & 15);
            bg.ch.g = 4'((v >> 6) & 15);
            bg.ch.b = 4'd4;
        end
        if (in_range(h, rx, int'(rect_width)) && in_range(v, ry, int'(rect_height))) begin
            px.ch.r = half_sum(rc.ch.r, bg.ch.r);
            px.ch.g = half_sum(rc.ch.g, bg.ch.g);
            px.ch.b = half_sum(rc.ch.b, bg.ch.b);
            return px;
        end
        return bg;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_rgb(input string test, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] %s: rgb at (%0d,%0d) expected %03h actual %03h",
                                        test, h_pos, v_pos, exp.word, act.word));
        end
    endtask

    task automatic check_sync(input string test, input string sig, input logic exp,
                              input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] %s: %s at (%0d,%0d) expected %b actual %b",
                                        test, sig, h_pos, v_pos, exp, act));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster model and checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (rst) begin
            check_rgb("reset", '0, rgb);
            check_sync("reset", "hsync", 1'b0, hsync);
            check_sync("reset", "vsync", 1'b0, vsync);
        end else begin
            h_step = (h_pos == h_total - 1) ? 0 : h_pos + 1;
            v_step = v_pos;
            if (h_step == 0) begin
                v_step = (v_pos == v_total - 1) ? 0 : v_pos + 1;
            end
            // A sync edge pins the model to the raster; once locked it must agree.
            if (hsync && !hs_prev) begin
                if (h_lock && h_step != int'(hor_sync_start)) begin
                    stop_with_failure($sformatf("hsync rose at pixel %0d of the line", h_step));
                end
                h_step = int'(hor_sync_start);
                h_lock = 1'b1;
            end
            if (vsync && !vs_prev) begin
                if (v_lock && (v_step != int'(ver_sync_start) || h_step != 0)) begin
                    stop_with_failure($sformatf("vsync rose at line %0d, pixel %0d",
                                                v_step, h_step));
                end
                v_step = int'(ver_sync_start);
                v_lock = 1'b1;
            end
            h_pos = h_step;
            v_pos = v_step;
            if (h_lock && v_lock) begin
                // The position applied during the last vertical blank governs this frame.
                if (h_pos == 0 && v_pos == 0 && applied_idx >= 0) begin
                    cur_x       = tbl_x[applied_idx];
                    cur_y       = tbl_y[applied_idx];
                    frame_name  = tbl_name[applied_idx];
                    frames_seen = frames_seen + 1;
                end
                check_sync(frame_name, "hsync",
                           in_range(h_pos, int'(hor_sync_start), int'(hor_sync_time)), hsync);
                check_sync(frame_name, "vsync",
                           in_range(v_pos, int'(ver_sync_start), int'(ver_sync_time)), vsync);
                check_rgb(frame_name, expected_pixel(h_pos, v_pos, cur_x, cur_y), rgb);
            end
        end
        hs_prev = hsync;
        vs_prev = vsync;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                        cycle_limit));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic build_table();
        logic [31:0] rnd;
        tbl_name[0] = "centre";
        tbl_x[0]    = 376;
        tbl_y[0]    = 268;
        tbl_name[1] = "origin";
        tbl_x[1]    = 0;
        tbl_y[1]    = 0;
        tbl_name[2] = "bottom_right_clipped";
        tbl_x[2]    = 780;
        tbl_y[2]    = 570;
        tbl_name[3] = "border_overlap";
        tbl_x[3]    = 799;
        tbl_y[3]    = 599;
        rnd         = xorshift(32'd37729);
        tbl_name[4] = "random";
        tbl_x[4]    = int'(rnd % 32'd800);
        rnd         = xorshift(rnd);
        tbl_y[4]    = int'(rnd % 32'd600);
    endtask

    initial begin
        rst    = 1'b1;
        rect_x = '0;
        rect_y = '0;
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // The first frame after reset is partial; each entry takes the next full frame.
        for (int i = 0; i < n_tests; i++) begin
            @(posedge vsync);
            @(negedge clk);
            rect_x      = cnt_w'(tbl_x[i]);
            rect_y      = cnt_w'(tbl_y[i]);
            applied_idx = i;
        end
        @(posedge vsync);
        @(negedge clk);
        if (frames_seen == n_tests) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d frames were checked", frames_seen, n_tests);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: tb.f
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_background.sv
verilog/draw_rect.sv
verilog/pixel_mixer.sv
verilog/vga_top.sv
testbench/vga_top_tb.sv

// File: Bender.yml
package:
  name: vga_rect

sources:
  # Package first, then the leaf modules and the top level.
  - verilog/vga_pkg.sv
  - verilog/vga_timing.sv
  - verilog/draw_background.sv
  - verilog/draw_rect.sv
  - verilog/pixel_mixer.sv
  - verilog/vga_top.sv

  - target: test
    files:
      - testbench/vga_top_tb.sv

# Simulation top: vga_top_tb
# Design top: vga_top
